// ==== hdl/rvv_pkg.sv ====
`default_nettype none

package rvv_pkg;

  // Fixed vector configuration: SEW 8, LMUL 1, vl 16
  localparam int vlen      = 128;
  localparam int sew       = 8;
  localparam int num_elem  = vlen / sew;
  localparam int xlen      = 32;
  localparam int num_vregs = 32;

  typedef logic [vlen-1:0] vreg_t;
  typedef logic [sew-1:0]  elem_t;
  typedef logic [xlen-1:0] xdata_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [2:0]      rob_idx_t;

  typedef enum logic [2:0] {
    op_add_vv,
    op_sub_vv,
    op_and_vv,
    op_add_vx,
    op_redsum,
    op_mv_xs
  } alu_op_e;

  // Instruction word plus rs1 value from the scalar core
  typedef struct packed {
    inst_t  inst;
    xdata_t rs1_data;
  } rvv_cmd_t;

  typedef struct packed {
    alu_op_e  op;
    reg_idx_t vd;
    reg_idx_t vs1;
    reg_idx_t vs2;
    xdata_t   scalar;
  } uop_t;

  typedef struct packed {
    alu_op_e  op;
    rob_idx_t rob_idx;
    vreg_t    vs1_data;
    vreg_t    vs2_data;
    xdata_t   scalar;
  } alu_uop_t;

endpackage

`default_nettype wire

// ==== hdl/rvv_alloc_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rvv_alloc_if
  import rvv_pkg::*;
();
  logic     alloc_valid;
  reg_idx_t alloc_dest;
  logic     alloc_to_xrf;
  // Ready means the ROB has a free entry at the tail
  logic     alloc_ready;
  rob_idx_t alloc_idx;

  modport dispatch (
    output alloc_valid,
    output alloc_dest,
    output alloc_to_xrf,
    input  alloc_ready,
    input  alloc_idx
  );

  modport rob (
    input  alloc_valid,
    input  alloc_dest,
    input  alloc_to_xrf,
    output alloc_ready,
    output alloc_idx
  );
endinterface

`default_nettype wire

// ==== hdl/rvv_multi_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_multi_fifo #(
  parameter type t     = logic [7:0],
  parameter int  m     = 1,
  parameter int  n     = 1,
  parameter int  depth = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [m-1:0] push,
  input  t     [m-1:0] datain,
  input  logic [n-1:0] pop,
  output t     [n-1:0] dataout,
  output logic         full,
  output logic         almost_full,
  output logic         empty,
  output logic         almost_empty
);

  // Depth is a power of two so the pointers wrap on their own
  localparam int aw = $clog2(depth);
  localparam int cw = $clog2(depth + 1);

  t              mem [depth];
  logic [aw-1:0] wptr;
  logic [aw-1:0] rptr;
  logic [cw-1:0] cnt;
  logic [cw-1:0] push_num;
  logic [cw-1:0] pop_num;

  // Ports are used as a contiguous group from port 0
  always_comb begin
    push_num = '0;
    for (int i = 0; i < m; i++) begin
      push_num = push_num + cw'(push[i]);
    end
  end

  always_comb begin
    pop_num = '0;
    for (int i = 0; i < n; i++) begin
      pop_num = pop_num + cw'(pop[i]);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < m; i++) begin
      if (push[i]) begin
        mem[wptr + aw'(i)] <= datain[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr <= '0;
      rptr <= '0;
      cnt  <= '0;
    end else begin
      wptr <= wptr + aw'(push_num);
      rptr <= rptr + aw'(pop_num);
      cnt  <= cnt + push_num - pop_num;
    end
  end

  // Read ports look ahead from the read pointer
  always_comb begin
    for (int i = 0; i < n; i++) begin
      dataout[i] = mem[rptr + aw'(i)];
    end
  end

  assign full         = (cnt == cw'(depth));
  assign empty        = (cnt == '0);
  // Not enough room or entries to serve every port
  assign almost_full  = ((cw'(depth) - cnt) < cw'(m));
  assign almost_empty = (cnt < cw'(n));

endmodule

`default_nettype wire

// ==== hdl/rvv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_decode
  import rvv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  rvv_cmd_t cmd,
  input  logic     cmd_empty,
  output logic     cmd_pop,
  input  logic     uq_full,
  output logic     uop_push,
  output uop_t     uop
);

  localparam logic [6:0] opcode_v = 7'b1010111;
  localparam logic [2:0] opivv    = 3'b000;
  localparam logic [2:0] opmvv    = 3'b010;
  localparam logic [2:0] opivx    = 3'b100;

  logic [5:0] funct6;
  logic [2:0] funct3;
  logic       vm;
  logic       supported;
  alu_op_e    op;
  logic       out_valid;
  logic       out_free;

  assign funct6 = cmd.inst[31:26];
  assign vm     = cmd.inst[25];
  assign funct3 = cmd.inst[14:12];

  // Masked forms are not supported, vm must be set
  always_comb begin
    supported = 1'b0;
    op        = op_add_vv;
    if (cmd.inst[6:0] == opcode_v && vm) begin
      case (funct3)
        opivv: begin
          supported = 1'b1;
          case (funct6)
            6'b000000: op = op_add_vv;
            6'b000010: op = op_sub_vv;
            6'b001001: op = op_and_vv;
            default:   supported = 1'b0;
          endcase
        end
        opivx: begin
          supported = (funct6 == 6'b000000);
          op        = op_add_vx;
        end
        opmvv: begin
          case (funct6)
            6'b000000: begin
              supported = 1'b1;
              op        = op_redsum;
            end
            // vmv.x.s has vs1 field fixed at zero
            6'b010000: begin
              supported = (cmd.inst[19:15] == 5'd0);
              op        = op_mv_xs;
            end
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // Output register, holds while the uop queue is full
  assign uop_push = out_valid && !uq_full;
  assign out_free = !out_valid || uop_push;
  assign cmd_pop  = !cmd_empty && out_free;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (cmd_pop) begin
      out_valid <= supported;
    end else if (uop_push) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_pop && supported) begin
      uop.op     <= op;
      uop.vd     <= cmd.inst[11:7];
      uop.vs1    <= cmd.inst[19:15];
      uop.vs2    <= cmd.inst[24:20];
      uop.scalar <= cmd.rs1_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rvv_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_dispatch
  import rvv_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  uop_t                 uop,
  input  logic                 uq_empty,
  output logic                 uq_pop,
  input  logic [num_vregs-1:0] busy_vregs,
  output reg_idx_t [1:0]       vrf_rd_idx,
  input  vreg_t    [1:0]       vrf_rd_data,
  input  logic                 rs_full,
  output logic                 rs_push,
  output alu_uop_t             rs_data,
  rvv_alloc_if.dispatch        alloc
);

  logic uses_vs1;
  logic src_busy;
  logic out_valid;
  logic out_free;
  logic issue;

  // vadd.vx and vmv.x.s read no vector through the vs1 field
  assign uses_vs1 = (uop.op != op_add_vx) && (uop.op != op_mv_xs);
  assign src_busy = busy_vregs[uop.vs2] || (uses_vs1 && busy_vregs[uop.vs1]);

  assign vrf_rd_idx[0] = uop.vs1;
  assign vrf_rd_idx[1] = uop.vs2;

  // Skid register in front of the RS
  assign rs_push  = out_valid && !rs_full;
  assign out_free = !out_valid || rs_push;

  assign alloc.alloc_valid  = !uq_empty && !src_busy && out_free;
  assign alloc.alloc_dest   = uop.vd;
  assign alloc.alloc_to_xrf = (uop.op == op_mv_xs);

  assign issue  = alloc.alloc_valid && alloc.alloc_ready;
  assign uq_pop = issue;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (issue) begin
      out_valid <= 1'b1;
    end else if (rs_push) begin
      out_valid <= 1'b0;
    end
  end

  // Operands are captured together with the ROB tail index
  always_ff @(posedge clk) begin
    if (issue) begin
      rs_data.op       <= uop.op;
      rs_data.rob_idx  <= alloc.alloc_idx;
      rs_data.vs1_data <= vrf_rd_data[0];
      rs_data.vs2_data <= vrf_rd_data[1];
      rs_data.scalar   <= uop.scalar;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rvv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_alu
  import rvv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  alu_uop_t rs_data,
  input  logic     rs_empty,
  output logic     rs_pop,
  output logic     wb_valid,
  output rob_idx_t wb_idx,
  output vreg_t    wb_data
);

  vreg_t va;
  vreg_t vb;
  vreg_t add_vv;
  vreg_t sub_vv;
  vreg_t add_vx;
  vreg_t result;
  elem_t red_sum;

  assign rs_pop = !rs_empty;
  assign va     = rs_data.vs1_data;
  assign vb     = rs_data.vs2_data;

  // All lanes wrap modulo 256
  always_comb begin
    red_sum = va[sew-1:0];
    for (int e = 0; e < num_elem; e++) begin
      add_vv[e*sew +: sew] = vb[e*sew +: sew] + va[e*sew +: sew];
      sub_vv[e*sew +: sew] = vb[e*sew +: sew] - va[e*sew +: sew];
      add_vx[e*sew +: sew] = vb[e*sew +: sew] + rs_data.scalar[sew-1:0];
      red_sum              = red_sum + vb[e*sew +: sew];
    end
  end

  always_comb begin
    case (rs_data.op)
      op_add_vv: result = add_vv;
      op_sub_vv: result = sub_vv;
      op_and_vv: result = vb & va;
      op_add_vx: result = add_vx;
      // Sum lands in element 0, rest comes from vs1
      op_redsum: result = {va[vlen-1:sew], red_sum};
      op_mv_xs:  result = {{(vlen-xlen){1'b0}}, {(xlen-sew){vb[sew-1]}}, vb[sew-1:0]};
      default:   result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= rs_pop;
    end
  end

  always_ff @(posedge clk) begin
    wb_idx  <= rs_data.rob_idx;
    wb_data <= result;
  end

endmodule

`default_nettype wire

// ==== hdl/rvv_rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_rob
  import rvv_pkg::*;
#(
  parameter int depth = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  rvv_alloc_if.rob             alloc,
  input  logic                 wb_valid,
  input  rob_idx_t             wb_idx,
  input  vreg_t                wb_data,
  output logic [num_vregs-1:0] busy_vregs,
  output logic                 vrf_wr_valid,
  output reg_idx_t             vrf_wr_idx,
  output vreg_t                vrf_wr_data,
  output logic                 rt_xrf_valid,
  output reg_idx_t             rt_xrf_rd,
  output xdata_t               rt_xrf_data,
  input  logic                 rt_xrf_ready
);

  logic [depth-1:0] ent_valid;
  logic [depth-1:0] ent_done;
  logic [depth-1:0] ent_to_xrf;
  reg_idx_t         ent_dest [depth];
  vreg_t            ent_data [depth];
  rob_idx_t         head;
  rob_idx_t         tail;
  logic             head_done;
  logic             alloc_fire;
  logic             retire;

  function automatic rob_idx_t ptr_inc(rob_idx_t p);
    return (p == rob_idx_t'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // Tail entry still in use means the ring is full
  assign alloc.alloc_ready = !ent_valid[tail];
  assign alloc.alloc_idx   = tail;
  assign alloc_fire        = alloc.alloc_valid && alloc.alloc_ready;

  assign head_done    = ent_valid[head] && ent_done[head];
  assign vrf_wr_valid = head_done && !ent_to_xrf[head];
  assign vrf_wr_idx   = ent_dest[head];
  assign vrf_wr_data  = ent_data[head];
  // Head holds until the scalar side takes it
  assign rt_xrf_valid = head_done && ent_to_xrf[head];
  assign rt_xrf_rd    = ent_dest[head];
  assign rt_xrf_data  = ent_data[head][xlen-1:0];
  assign retire       = vrf_wr_valid || (rt_xrf_valid && rt_xrf_ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head      <= '0;
      tail      <= '0;
    end else begin
      if (alloc_fire) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= ptr_inc(tail);
      end
      if (wb_valid) begin
        ent_done[wb_idx] <= 1'b1;
      end
      if (retire) begin
        ent_valid[head] <= 1'b0;
        head            <= ptr_inc(head);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      ent_dest[tail]   <= alloc.alloc_dest;
      ent_to_xrf[tail] <= alloc.alloc_to_xrf;
    end
    if (wb_valid) begin
      ent_data[wb_idx] <= wb_data;
    end
  end

  // Vector destinations still waiting to be written back
  always_comb begin
    busy_vregs = '0;
    for (int i = 0; i < depth; i++) begin
      if (ent_valid[i] && !ent_to_xrf[i]) begin
        busy_vregs[ent_dest[i]] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rvv_vrf.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_vrf
  import rvv_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  reg_idx_t [1:0] rd_idx,
  output vreg_t    [1:0] rd_data,
  input  logic           wr_valid,
  input  reg_idx_t       wr_idx,
  input  vreg_t          wr_data
);

  vreg_t regs [num_vregs];

  // Every byte of register k starts out as k
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < num_vregs; k++) begin
        regs[k] <= {num_elem{elem_t'(k)}};
      end
    end else if (wr_valid) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Asynchronous read for dispatch
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rd_data[p] = regs[rd_idx[p]];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rvv_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_backend
  import rvv_pkg::*;
#(
  parameter int issue_lanes = 2,
  parameter int cq_depth    = 8,
  parameter int uq_depth    = 4,
  parameter int rs_depth    = 4,
  parameter int rob_depth   = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic     [issue_lanes-1:0] insts_valid,
  input  rvv_cmd_t [issue_lanes-1:0] insts,
  output logic     [issue_lanes-1:0] insts_ready,
  output logic                      rt_xrf_valid,
  output reg_idx_t                  rt_xrf_rd,
  output xdata_t                    rt_xrf_data,
  input  logic                      rt_xrf_ready
);

  logic                 cq_full;
  logic                 cq_almost_full;
  rvv_cmd_t             cmd;
  logic                 cmd_empty;
  logic                 cmd_pop;
  uop_t                 uop_de2uq;
  logic                 uop_push;
  logic                 uq_full;
  uop_t                 uop_uq2dp;
  logic                 uq_empty;
  logic                 uq_pop;
  alu_uop_t             rs_data_dp2rs;
  logic                 rs_push;
  logic                 rs_full;
  alu_uop_t             rs_data_rs2alu;
  logic                 rs_empty;
  logic                 rs_pop;
  logic                 wb_valid;
  rob_idx_t             wb_idx;
  vreg_t                wb_data;
  logic [num_vregs-1:0] busy_vregs;
  logic                 vrf_wr_valid;
  reg_idx_t             vrf_wr_idx;
  vreg_t                vrf_wr_data;
  reg_idx_t [1:0]       vrf_rd_idx;
  vreg_t    [1:0]       vrf_rd_data;

  rvv_alloc_if alloc_if ();

  // Lane i needs i+1 free slots, so lane 1 implies lane 0
  assign insts_ready[0] = !cq_full;
  for (genvar i = 1; i < issue_lanes; i++) begin : g_lane_ready
    assign insts_ready[i] = !cq_almost_full;
  end

  rvv_multi_fifo #(.t(rvv_cmd_t), .m(issue_lanes), .n(1), .depth(cq_depth)) u_command_queue (
    .clk(clk), .rst_n(rst_n),
    .push(insts_valid & insts_ready), .datain(insts),
    .pop(cmd_pop), .dataout(cmd),
    .full(cq_full), .almost_full(cq_almost_full),
    .empty(cmd_empty), .almost_empty()
  );

  rvv_decode u_decode (
    .clk(clk), .rst_n(rst_n),
    .cmd(cmd), .cmd_empty(cmd_empty), .cmd_pop(cmd_pop),
    .uq_full(uq_full), .uop_push(uop_push), .uop(uop_de2uq)
  );

  rvv_multi_fifo #(.t(uop_t), .m(1), .n(1), .depth(uq_depth)) u_uop_queue (
    .clk(clk), .rst_n(rst_n),
    .push(uop_push), .datain(uop_de2uq),
    .pop(uq_pop), .dataout(uop_uq2dp),
    .full(uq_full), .almost_full(),
    .empty(uq_empty), .almost_empty()
  );

  rvv_dispatch u_dispatch (
    .clk(clk), .rst_n(rst_n),
    .uop(uop_uq2dp), .uq_empty(uq_empty), .uq_pop(uq_pop),
    .busy_vregs(busy_vregs),
    .vrf_rd_idx(vrf_rd_idx), .vrf_rd_data(vrf_rd_data),
    .rs_full(rs_full), .rs_push(rs_push), .rs_data(rs_data_dp2rs),
    .alloc(alloc_if.dispatch)
  );

  rvv_multi_fifo #(.t(alu_uop_t), .m(1), .n(1), .depth(rs_depth)) u_alu_rs (
    .clk(clk), .rst_n(rst_n),
    .push(rs_push), .datain(rs_data_dp2rs),
    .pop(rs_pop), .dataout(rs_data_rs2alu),
    .full(rs_full), .almost_full(),
    .empty(rs_empty), .almost_empty()
  );

  rvv_alu u_alu (
    .clk(clk), .rst_n(rst_n),
    .rs_data(rs_data_rs2alu), .rs_empty(rs_empty), .rs_pop(rs_pop),
    .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data)
  );

  rvv_rob #(.depth(rob_depth)) u_rob (
    .clk(clk), .rst_n(rst_n),
    .alloc(alloc_if.rob),
    .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data),
    .busy_vregs(busy_vregs),
    .vrf_wr_valid(vrf_wr_valid), .vrf_wr_idx(vrf_wr_idx), .vrf_wr_data(vrf_wr_data),
    .rt_xrf_valid(rt_xrf_valid), .rt_xrf_rd(rt_xrf_rd), .rt_xrf_data(rt_xrf_data),
    .rt_xrf_ready(rt_xrf_ready)
  );

  rvv_vrf u_vrf (
    .clk(clk), .rst_n(rst_n),
    .rd_idx(vrf_rd_idx), .rd_data(vrf_rd_data),
    .wr_valid(vrf_wr_valid), .wr_idx(vrf_wr_idx), .wr_data(vrf_wr_data)
  );

endmodule

`default_nettype wire

// ==== test/rvv_backend_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_checker
  import rvv_pkg::*;
#(
  parameter int lanes = 2
) (
  input logic             clk,
  input logic             rst_n,
  input logic [lanes-1:0] insts_valid,
  input logic [lanes-1:0] insts_ready,
  input logic             rt_xrf_valid,
  input reg_idx_t         rt_xrf_rd,
  input xdata_t           rt_xrf_data,
  input logic             rt_xrf_ready
);

  int unsigned fail_count = 0;
  // Low until the first edge has passed
  logic        started = 1'b0;

  always @(posedge clk) begin
    started <= 1'b1;
  end

  // Lane 1 is the younger instruction
  a_lane_order: assert property (@(posedge clk) disable iff (!rst_n)
    (insts_valid[1] && insts_ready[1]) |-> (insts_valid[0] && insts_ready[0]))
    else begin
      fail_count++;
      $error("lane 1 accepted without lane 0");
    end

  a_xrf_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_xrf_valid && !rt_xrf_ready) |=>
      (rt_xrf_valid && $stable(rt_xrf_rd) && $stable(rt_xrf_data)))
    else begin
      fail_count++;
      $error("XRF retire port changed while stalled");
    end

  a_reset_quiet: assert property (@(posedge clk)
    (started && !rst_n) |-> !rt_xrf_valid)
    else begin
      fail_count++;
      $error("rt_xrf_valid high during reset");
    end

endmodule

bind rvv_backend rvv_backend_checker #(.lanes(issue_lanes)) u_checker (
  .clk(clk), .rst_n(rst_n),
  .insts_valid(insts_valid), .insts_ready(insts_ready),
  .rt_xrf_valid(rt_xrf_valid), .rt_xrf_rd(rt_xrf_rd),
  .rt_xrf_data(rt_xrf_data), .rt_xrf_ready(rt_xrf_ready)
);

`default_nettype wire

// ==== test/tb_rvv_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_backend
  import rvv_pkg::*;
();

  localparam int stall_limit = 2000;

  logic           clk;
  logic           rst_n;
  logic     [1:0] insts_valid;
  rvv_cmd_t [1:0] insts;
  logic     [1:0] insts_ready;
  logic           rt_xrf_valid;
  reg_idx_t       rt_xrf_rd;
  xdata_t         rt_xrf_data;
  logic           rt_xrf_ready;

  integer   seed;
  logic     rand_ready_en;
  vreg_t    ref_vrf [num_vregs];
  rvv_cmd_t stim_q [$];
  reg_idx_t exp_rd [$];
  xdata_t   exp_data [$];

  rvv_backend #(
    .issue_lanes(2), .cq_depth(8), .uq_depth(4), .rs_depth(4), .rob_depth(8)
  ) u_dut (
    .clk(clk), .rst_n(rst_n),
    .insts_valid(insts_valid), .insts(insts), .insts_ready(insts_ready),
    .rt_xrf_valid(rt_xrf_valid), .rt_xrf_rd(rt_xrf_rd),
    .rt_xrf_data(rt_xrf_data), .rt_xrf_ready(rt_xrf_ready)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rd(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s got %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_xdata(input string name, input xdata_t got, input xdata_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s got %h, expected %h", $time, name, got, exp));
    end
  endtask

  function automatic rvv_cmd_t make_cmd(input logic [5:0] f6, input logic [2:0] f3,
                                        input reg_idx_t vd, input reg_idx_t vs1,
                                        input reg_idx_t vs2, input xdata_t x);
    rvv_cmd_t c;
    c.inst     = {f6, 1'b1, vs2, vs1, f3, vd, 7'b1010111};
    c.rs1_data = x;
    return c;
  endfunction

  function automatic rvv_cmd_t mv_xs(input reg_idx_t rd, input reg_idx_t vs2);
    return make_cmd(6'b010000, 3'b010, rd, 5'd0, vs2, '0);
  endfunction

  // Reference model, updates ref_vrf and returns 1 for a scalar result
  function automatic logic ref_exec(input rvv_cmd_t c, output xdata_t xval);
    vreg_t a;
    vreg_t b;
    vreg_t r;
    elem_t acc;
    xval = '0;
    a    = ref_vrf[c.inst[19:15]];
    b    = ref_vrf[c.inst[24:20]];
    r    = a;
    acc  = a[sew-1:0];
    if (c.inst[6:0] != 7'b1010111 || !c.inst[25]) begin
      return 1'b0;
    end
    case ({c.inst[14:12], c.inst[31:26]})
      9'b000_000000: begin
        for (int e = 0; e < num_elem; e++) begin
          r[e*sew +: sew] = b[e*sew +: sew] + a[e*sew +: sew];
        end
      end
      9'b000_000010: begin
        for (int e = 0; e < num_elem; e++) begin
          r[e*sew +: sew] = b[e*sew +: sew] - a[e*sew +: sew];
        end
      end
      9'b000_001001: r = b & a;
      9'b100_000000: begin
        for (int e = 0; e < num_elem; e++) begin
          r[e*sew +: sew] = b[e*sew +: sew] + c.rs1_data[7:0];
        end
      end
      9'b010_000000: begin
        for (int e = 0; e < num_elem; e++) acc = acc + b[e*sew +: sew];
        r[sew-1:0] = acc;
      end
      9'b010_010000: begin
        xval = {{(xlen-sew){b[sew-1]}}, b[sew-1:0]};
        return (c.inst[19:15] == 5'd0);
      end
      default: return 1'b0;
    endcase
    ref_vrf[c.inst[11:7]] = r;
    return 1'b0;
  endfunction

  function automatic rvv_cmd_t rand_cmd();
    int       kind;
    reg_idx_t vd;
    reg_idx_t vs1;
    reg_idx_t vs2;
    xdata_t   x;
    rvv_cmd_t c;
    kind = {$random(seed)} % 9;
    vd   = reg_idx_t'($random(seed));
    vs1  = reg_idx_t'($random(seed));
    vs2  = reg_idx_t'($random(seed));
    x    = $random(seed);
    case (kind)
      0: c = make_cmd(6'b000000, 3'b000, vd, vs1, vs2, x);
      1: c = make_cmd(6'b000010, 3'b000, vd, vs1, vs2, x);
      2: c = make_cmd(6'b001001, 3'b000, vd, vs1, vs2, x);
      3: c = make_cmd(6'b000000, 3'b100, vd, vs1, vs2, x);
      4: c = make_cmd(6'b000000, 3'b010, vd, vs1, vs2, x);
      5, 6: c = mv_xs(vd, vs2);
      // Masked form
      7: begin
        c = make_cmd(6'b000000, 3'b000, vd, vs1, vs2, x);
        c.inst[25] = 1'b0;
      end
      // vmul.vv, or a scalar opcode
      default: begin
        c = make_cmd(6'b100101, 3'b010, vd, vs1, vs2, x);
        if (x[0]) c.inst[6:0] = 7'b0110011;
      end
    endcase
    return c;
  endfunction

  task automatic model_accept(input rvv_cmd_t c);
    xdata_t xv;
    if (ref_exec(c, xv)) begin
      exp_rd.push_back(c.inst[11:7]);
      exp_data.push_back(xv);
    end
  endtask

  // Presents queued commands on one or two lanes in program order
  task automatic send_queued();
    int lanes;
    int stalls;
    stalls = 0;
    while (stim_q.size() > 0) begin
      lanes = (stim_q.size() > 1 && ($random(seed) & 1)) ? 2 : 1;
      @(posedge clk);
      #1;
      insts          = '0;
      insts_valid    = '0;
      insts[0]       = stim_q[0];
      insts_valid[0] = 1'b1;
      if (lanes == 2) begin
        insts[1]       = stim_q[1];
        insts_valid[1] = 1'b1;
      end
      @(negedge clk);
      if (insts_ready[0]) begin
        model_accept(stim_q.pop_front());
        if (lanes == 2 && insts_ready[1]) model_accept(stim_q.pop_front());
        stalls = 0;
      end else begin
        stalls++;
        if (stalls > stall_limit) abort_run("Command queue never became ready");
      end
    end
    @(posedge clk);
    #1;
    insts_valid = '0;
    @(negedge clk);
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_rd.size() > 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > stall_limit) abort_run("Expected scalar results never retired");
    end
    @(negedge clk);
  endtask

  // Scalar side back-pressure
  always @(posedge clk) begin
    #1;
    rt_xrf_ready = rand_ready_en ? (($random(seed) & 3) != 0) : 1'b1;
  end

  always @(negedge clk) begin
    if (rst_n && rt_xrf_valid && rt_xrf_ready) begin
      if (exp_rd.size() == 0) begin
        abort_run($sformatf("Scalar result for x%0d arrived with none expected", rt_xrf_rd));
      end else begin
        check_rd("rt_xrf_rd", rt_xrf_rd, exp_rd.pop_front());
        check_xdata("rt_xrf_data", rt_xrf_data, exp_data.pop_front());
      end
    end
  end

  initial begin
    reg_idx_t r;
    clk           = 1'b0;
    rst_n         = 1'b0;
    insts_valid   = '0;
    insts         = '0;
    rt_xrf_ready  = 1'b1;
    rand_ready_en = 1'b0;
    seed          = 32'he5bc8235;
    for (int k = 0; k < num_vregs; k++) ref_vrf[k] = {num_elem{elem_t'(k)}};
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);

    // Empty queues accept on both lanes
    if (insts_ready !== 2'b11) begin
      abort_run($sformatf("Error at %0t: insts_ready got %b, expected %b",
                          $time, insts_ready, 2'b11));
    end

    for (int k = 0; k < num_vregs; k++) stim_q.push_back(mv_xs(reg_idx_t'(k), reg_idx_t'(k)));
    send_queued();
    wait_drained();

    // Element-wise ops, then a back-to-back chain on v8
    stim_q.push_back(make_cmd(6'b000000, 3'b000, 5'd1, 5'd2, 5'd3, '0));
    stim_q.push_back(make_cmd(6'b000010, 3'b000, 5'd4, 5'd9, 5'd1, '0));
    stim_q.push_back(make_cmd(6'b001001, 3'b000, 5'd6, 5'd4, 5'd1, '0));
    stim_q.push_back(make_cmd(6'b000000, 3'b100, 5'd7, 5'd3, 5'd6, 32'h12345681));
    for (int i = 0; i < 6; i++) stim_q.push_back(make_cmd(6'b000000, 3'b000, 5'd8, 5'd20, 5'd8, '0));
    stim_q.push_back(mv_xs(5'd1, 5'd1));
    stim_q.push_back(mv_xs(5'd4, 5'd4));
    stim_q.push_back(mv_xs(5'd6, 5'd6));
    stim_q.push_back(mv_xs(5'd7, 5'd7));
    stim_q.push_back(mv_xs(5'd8, 5'd8));
    send_queued();
    wait_drained();

    // Scramble register contents, then reduce
    for (int i = 0; i < 24; i++) begin
      r = reg_idx_t'($random(seed));
      stim_q.push_back(make_cmd(6'b000000, 3'b100, r, 5'd0, r, $random(seed)));
    end
    for (int i = 0; i < 12; i++) begin
      r = reg_idx_t'($random(seed));
      stim_q.push_back(make_cmd(6'b000000, 3'b010, r, reg_idx_t'($random(seed)),
                                reg_idx_t'($random(seed)), '0));
      stim_q.push_back(mv_xs(r, r));
    end
    send_queued();
    wait_drained();

    for (int pass = 0; pass < 2; pass++) begin
      rand_ready_en = (pass == 1);
      for (int i = 0; i < 200; i++) stim_q.push_back(rand_cmd());
      for (int k = 0; k < num_vregs; k++) stim_q.push_back(mv_xs(reg_idx_t'(k), reg_idx_t'(k)));
      send_queued();
      wait_drained();
    end
    rand_ready_en = 1'b0;

    if (u_dut.u_checker.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/rvv_pkg.sv
hdl/rvv_alloc_if.sv
hdl/rvv_multi_fifo.sv
hdl/rvv_decode.sv
hdl/rvv_dispatch.sv
hdl/rvv_alu.sv
hdl/rvv_rob.sv
hdl/rvv_vrf.sv
hdl/rvv_backend.sv
test/rvv_backend_checker.sv
test/tb_rvv_backend.sv
